// File: verification/mem_cases.txt
// kind vaddr wdata byteenable expected, all hex
// kind 0 fetch, 1 load, 2 store, 3 burst count, 4 araddr, 5 awaddr, 6 fetch with store at vaddr+100
0 80000100 00000000 0 4bee011e
0 a0000100 00000000 0 4bee011e
0 8000010c 00000000 0 4ef10421
3 00000000 00000000 0 00000001
0 80000110 00000000 0 4ff20522
3 00000000 00000000 0 00000002
0 80000500 00000000 0 4cef021e
0 80000100 00000000 0 4bee011e
3 00000000 00000000 0 00000004
1 a0000200 00000000 0 8c2e415e
4 00000000 00000000 0 00000200
2 a0000200 11223344 5 00000000
5 00000000 00000000 0 00000200
1 a0000200 00000000 0 8c224144
1 00000204 00000000 0 8d2f425f
4 00000000 00000000 0 00000204
2 00000208 cafef00d f 00000000
5 00000000 00000000 0 00000208
1 a0000208 00000000 0 cafef00d
4 00000000 00000000 0 00000208
6 80000300 55aa55aa f cc6e819e
3 00000000 00000000 0 00000005
1 a0000400 00000000 0 55aa55aa

// File: project.f
hdl/bus_pkg.sv
hdl/mem_pkg.sv
hdl/cpu_bus_if.sv
hdl/icache.sv
hdl/uncached_bridge.sv
hdl/cache_controller.sv
hdl/mips_mem_top.sv
verification/tb_mips_mem_assert.sv
verification/tb_mips_mem.sv

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator and run the testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_mips_mem -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^All tests passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verification/tb_mips_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_mem import bus_pkg::*; ();

	logic              aclk;
	logic              rst_n;
	logic              ibus_read;
	logic [ADDR_W-1:0] ibus_address;
	logic [DATA_W-1:0] ibus_rddata;
	logic              ibus_stall;
	logic              dbus_read;
	logic              dbus_write;
	logic [ADDR_W-1:0] dbus_address;
	logic [DATA_W-1:0] dbus_wrdata;
	logic [STRB_W-1:0] dbus_byteenable;
	logic [DATA_W-1:0] dbus_rddata;
	logic              dbus_stall;
	logic [ADDR_W-1:0] icache_araddr;
	logic [LEN_W-1:0]  icache_arlen;
	logic              icache_arvalid;
	logic              icache_arready;
	logic [DATA_W-1:0] icache_rdata;
	logic              icache_rlast;
	logic              icache_rvalid;
	logic              icache_rready;
	logic [ADDR_W-1:0] uncached_araddr;
	logic              uncached_arvalid;
	logic              uncached_arready;
	logic [DATA_W-1:0] uncached_rdata;
	logic [1:0]        uncached_rresp;
	logic              uncached_rvalid;
	logic              uncached_rready;
	logic [ADDR_W-1:0] uncached_awaddr;
	logic              uncached_awvalid;
	logic              uncached_awready;
	logic [DATA_W-1:0] uncached_wdata;
	logic [STRB_W-1:0] uncached_wstrb;
	logic              uncached_wvalid;
	logic              uncached_wready;
	logic [1:0]        uncached_bresp;
	logic              uncached_bvalid;
	logic              uncached_bready;

	// Physical memory behind both AXI ports
	logic [DATA_W-1:0] mem [1024];
	logic [31:0] seed;
	int burst_count;
	int err_count;
	logic [ADDR_W-1:0] last_araddr;
	logic [ADDR_W-1:0] last_awaddr;

	logic [31:0] c_kind[$];
	logic [31:0] c_addr[$];
	logic [31:0] c_wdata[$];
	logic [31:0] c_be[$];
	logic [31:0] c_exp[$];

	mips_mem_top mips_mem_top_i (.*);

	initial aclk = 1'b0;
	always #2 aclk = ~aclk;

	task automatic report_failure(input string msg);
		err_count++;
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s read %h, expected %h", $time, what, got, exp);
			report_failure("read data mismatch");
		end
	endtask

	task automatic check_addr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("Error at %0t ns: %s was %h, expected %h", $time, what, got, exp);
			report_failure("address mismatch");
		end
	endtask

	task automatic check_count(input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t ns: %0d icache bursts, expected %0d", $time, got, exp);
			report_failure("burst count mismatch");
		end
	endtask

	function automatic int rand_delay();
		return int'({$random(seed)} % 3);
	endfunction

	function automatic logic [9:0] word_index(input logic [ADDR_W-1:0] addr);
		return addr[11:2];
	endfunction

	task automatic fetch_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		@(negedge aclk);
		ibus_read    = 1'b1;
		ibus_address = addr;
		#1;
		while (ibus_stall) begin
			@(negedge aclk);
			#1;
		end
		check_word(ibus_rddata, exp, "instruction fetch");
		@(negedge aclk);
		ibus_read = 1'b0;
	endtask

	task automatic load_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp);
		@(negedge aclk);
		dbus_read    = 1'b1;
		dbus_address = addr;
		#1;
		while (dbus_stall) begin
			@(negedge aclk);
			#1;
		end
		check_word(dbus_rddata, exp, "data load");
		@(negedge aclk);
		dbus_read = 1'b0;
	endtask

	task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
			input logic [STRB_W-1:0] be);
		@(negedge aclk);
		dbus_write      = 1'b1;
		dbus_address    = addr;
		dbus_wrdata     = data;
		dbus_byteenable = be;
		#1;
		while (dbus_stall) begin
			@(negedge aclk);
			#1;
		end
		@(negedge aclk);
		dbus_write = 1'b0;
	endtask

	task automatic serve_icache_burst();
		logic [ADDR_W-1:0] base;
		repeat (rand_delay()) @(negedge aclk);
		icache_arready = 1'b1;
		base = icache_araddr;
		if (base[3:0] != 4'h0)
			report_failure("icache burst start is not line aligned");
		if (icache_arlen != LEN_W'(3))
			report_failure("icache burst length is not four beats");
		if (base[31:12] != '0)
			report_failure("icache burst outside the memory model");
		burst_count++;
		@(negedge aclk);
		icache_arready = 1'b0;
		for (int beat = 0; beat < 4; beat++) begin
			repeat (rand_delay()) @(negedge aclk);
			icache_rvalid = 1'b1;
			icache_rdata  = mem[word_index(base + ADDR_W'(4 * beat))];
			icache_rlast  = (beat == 3);
			while (!icache_rready)
				@(negedge aclk);
			@(negedge aclk);
			icache_rvalid = 1'b0;
			icache_rlast  = 1'b0;
		end
	endtask

	task automatic serve_uncached_read();
		logic [ADDR_W-1:0] addr;
		repeat (rand_delay()) @(negedge aclk);
		uncached_arready = 1'b1;
		addr = uncached_araddr;
		last_araddr = addr;
		if (addr[31:12] != '0)
			report_failure("data read outside the memory model");
		@(negedge aclk);
		uncached_arready = 1'b0;
		repeat (rand_delay()) @(negedge aclk);
		uncached_rvalid = 1'b1;
		uncached_rdata  = mem[word_index(addr)];
		uncached_rresp  = resp_okay;
		while (!uncached_rready)
			@(negedge aclk);
		@(negedge aclk);
		uncached_rvalid = 1'b0;
	endtask

	task automatic serve_uncached_write();
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		repeat (rand_delay()) @(negedge aclk);
		uncached_awready = 1'b1;
		addr = uncached_awaddr;
		last_awaddr = addr;
		if (addr[31:12] != '0)
			report_failure("data write outside the memory model");
		@(negedge aclk);
		uncached_awready = 1'b0;
		while (!uncached_wvalid)
			@(negedge aclk);
		repeat (rand_delay()) @(negedge aclk);
		uncached_wready = 1'b1;
		data = uncached_wdata;
		strb = uncached_wstrb;
		@(negedge aclk);
		uncached_wready = 1'b0;
		for (int b = 0; b < STRB_W; b++)
			if (strb[b])
				mem[word_index(addr)][8*b +: 8] = data[8*b +: 8];
		repeat (rand_delay()) @(negedge aclk);
		uncached_bvalid = 1'b1;
		uncached_bresp  = resp_okay;
		while (!uncached_bready)
			@(negedge aclk);
		@(negedge aclk);
		uncached_bvalid = 1'b0;
	endtask

	initial begin : icache_slave
		forever begin
			@(negedge aclk);
			if (icache_arvalid)
				serve_icache_burst();
		end
	end

	initial begin : read_slave
		forever begin
			@(negedge aclk);
			if (uncached_arvalid)
				serve_uncached_read();
		end
	end

	initial begin : write_slave
		forever begin
			@(negedge aclk);
			if (uncached_awvalid)
				serve_uncached_write();
		end
	end

	task automatic read_cases();
		int fd;
		int n;
		string line;
		logic [31:0] k, a, w, b, e;
		fd = $fopen("verification/mem_cases.txt", "r");
		if (fd == 0)
			report_failure("could not open the case file");
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 2 || line[0] == "/")
				continue;
			n = $sscanf(line, "%h %h %h %h %h", k, a, w, b, e);
			if (n == 5) begin
				c_kind.push_back(k);
				c_addr.push_back(a);
				c_wdata.push_back(w);
				c_be.push_back(b);
				c_exp.push_back(e);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		seed = 32'hb7296cb7;
		burst_count = 0;
		err_count = 0;
		last_araddr = '0;
		last_awaddr = '0;
		rst_n = 1'b0;
		ibus_read = 1'b0;
		ibus_address = '0;
		dbus_read = 1'b0;
		dbus_write = 1'b0;
		dbus_address = '0;
		dbus_wrdata = '0;
		dbus_byteenable = '0;
		icache_arready = 1'b0;
		icache_rdata = '0;
		icache_rlast = 1'b0;
		icache_rvalid = 1'b0;
		uncached_arready = 1'b0;
		uncached_rdata = '0;
		uncached_rresp = '0;
		uncached_rvalid = 1'b0;
		uncached_awready = 1'b0;
		uncached_wready = 1'b0;
		uncached_bresp = '0;
		uncached_bvalid = 1'b0;
		for (int i = 0; i < 1024; i++)
			mem[i] = DATA_W'(i) * 32'h01010101 + 32'h0badc0de;
		read_cases();
		repeat (2) @(negedge aclk);
		rst_n = 1'b1;
		for (int i = 0; i < c_kind.size(); i++) begin
			case (c_kind[i])
				0: fetch_word(c_addr[i], c_exp[i]);
				1: load_word(c_addr[i], c_exp[i]);
				2: store_word(c_addr[i], c_wdata[i], c_be[i][STRB_W-1:0]);
				3: check_count(burst_count, int'(c_exp[i]));
				4: check_addr(last_araddr, c_exp[i], "uncached araddr");
				5: check_addr(last_awaddr, c_exp[i], "uncached awaddr");
				// Fill and store in flight together
				6: fork
					fetch_word(c_addr[i], c_exp[i]);
					store_word(c_addr[i] + 32'h100, c_wdata[i], c_be[i][STRB_W-1:0]);
				join
				default: report_failure("unknown case kind in the case file");
			endcase
		end
		err_count += mips_mem_top_i.cache_controller_i.icache_i.icache_chk.fail_count
			+ mips_mem_top_i.cache_controller_i.uncached_bridge_i.bridge_chk.fail_count;
		if (err_count == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Bound assertions failed %0d times", err_count);
			$display("Some tests failed");
			$fatal(1, "simulation stopped");
		end
	end

	initial begin : watchdog
		@(posedge rst_n);
		#((c_kind.size() * 40 + 100) * 4);
		$display("Timeout: the run did not finish in time");
		$display("Some tests failed");
		$fatal(1, "simulation stopped");
	end

endmodule

`default_nettype wire

// File: verification/tb_mips_mem_assert.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_mem_assert import bus_pkg::*; (
	input logic              aclk,
	input logic              rst_n,
	input logic              arvalid,
	input logic              arready,
	input logic [ADDR_W-1:0] araddr,
	input logic              awvalid,
	input logic              awready,
	input logic [ADDR_W-1:0] awaddr,
	input logic              wvalid,
	input logic              wready,
	input logic [DATA_W-1:0] wdata,
	input logic              req,
	input logic              stall
);

	int fail_count = 0;

	ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			fail_count++;
			$error("arvalid dropped or araddr changed before arready");
		end

	aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			fail_count++;
			$error("awvalid dropped or awaddr changed before awready");
		end

	w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			fail_count++;
			$error("wvalid dropped or wdata changed before wready");
		end

	ar_reset: assert property (@(posedge aclk) !rst_n |=> !arvalid)
		else begin
			fail_count++;
			$error("arvalid high after reset");
		end

	stall_first: assert property (@(posedge aclk) disable iff (!rst_n)
		req && !$past(req) |-> stall)
		else begin
			fail_count++;
			$error("stall low in the first cycle of a request");
		end

endmodule

bind icache tb_mips_mem_assert icache_chk (
	.aclk(aclk), .rst_n(rst_n),
	.arvalid(arvalid), .arready(arready), .araddr(araddr),
	.awvalid(1'b0), .awready(1'b0), .awaddr('0),
	.wvalid(1'b0), .wready(1'b0), .wdata('0),
	.req(ibus.read), .stall(ibus.stall)
);

bind uncached_bridge tb_mips_mem_assert bridge_chk (
	.aclk(aclk), .rst_n(rst_n),
	.arvalid(arvalid), .arready(arready), .araddr(araddr),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.wvalid(wvalid), .wready(wready), .wdata(wdata),
	.req(dbus.read || dbus.write), .stall(dbus.stall)
);

`default_nettype wire

// File: hdl/mips_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module mips_mem_top import bus_pkg::*; (
	input  logic              aclk,
	input  logic              rst_n,

	// Instruction bus
	input  logic              ibus_read,
	input  logic [ADDR_W-1:0] ibus_address,
	output logic [DATA_W-1:0] ibus_rddata,
	output logic              ibus_stall,

	// Data bus
	input  logic              dbus_read,
	input  logic              dbus_write,
	input  logic [ADDR_W-1:0] dbus_address,
	input  logic [DATA_W-1:0] dbus_wrdata,
	input  logic [STRB_W-1:0] dbus_byteenable,
	output logic [DATA_W-1:0] dbus_rddata,
	output logic              dbus_stall,

	// icache AXI
	output logic [ADDR_W-1:0] icache_araddr,
	output logic [LEN_W-1:0]  icache_arlen,
	output logic              icache_arvalid,
	input  logic              icache_arready,
	input  logic [DATA_W-1:0] icache_rdata,
	input  logic              icache_rlast,
	input  logic              icache_rvalid,
	output logic              icache_rready,

	// uncached AXI
	output logic [ADDR_W-1:0] uncached_araddr,
	output logic              uncached_arvalid,
	input  logic              uncached_arready,
	input  logic [DATA_W-1:0] uncached_rdata,
	input  logic [1:0]        uncached_rresp,
	input  logic              uncached_rvalid,
	output logic              uncached_rready,
	output logic [ADDR_W-1:0] uncached_awaddr,
	output logic              uncached_awvalid,
	input  logic              uncached_awready,
	output logic [DATA_W-1:0] uncached_wdata,
	output logic [STRB_W-1:0] uncached_wstrb,
	output logic              uncached_wvalid,
	input  logic              uncached_wready,
	input  logic [1:0]        uncached_bresp,
	input  logic              uncached_bvalid,
	output logic              uncached_bready
);

	cpu_ibus_if ibus_if();
	cpu_dbus_if dbus_if();

	// CPU side of the buses comes from the ports
	assign ibus_if.read    = ibus_read;
	assign ibus_if.address = ibus_address;
	assign ibus_rddata     = ibus_if.rddata;
	assign ibus_stall      = ibus_if.stall;

	assign dbus_if.read       = dbus_read;
	assign dbus_if.write      = dbus_write;
	assign dbus_if.address    = dbus_address;
	assign dbus_if.wrdata     = dbus_wrdata;
	assign dbus_if.byteenable = dbus_byteenable;
	assign dbus_rddata        = dbus_if.rddata;
	assign dbus_stall         = dbus_if.stall;

	cache_controller cache_controller_i (
		.*,
		.ibus (ibus_if.slave),
		.dbus (dbus_if.slave)
	);

endmodule

`default_nettype wire

// File: hdl/cache_controller.sv
`timescale 1ns/1ps
`default_nettype none

module cache_controller import bus_pkg::*, mem_pkg::*; (
	input  logic              aclk,
	input  logic              rst_n,

	cpu_ibus_if.slave         ibus,
	cpu_dbus_if.slave         dbus,

	output logic [ADDR_W-1:0] icache_araddr,
	output logic [LEN_W-1:0]  icache_arlen,
	output logic              icache_arvalid,
	input  logic              icache_arready,
	input  logic [DATA_W-1:0] icache_rdata,
	input  logic              icache_rlast,
	input  logic              icache_rvalid,
	output logic              icache_rready,

	output logic [ADDR_W-1:0] uncached_araddr,
	output logic              uncached_arvalid,
	input  logic              uncached_arready,
	input  logic [DATA_W-1:0] uncached_rdata,
	input  logic [1:0]        uncached_rresp,
	input  logic              uncached_rvalid,
	output logic              uncached_rready,
	output logic [ADDR_W-1:0] uncached_awaddr,
	output logic              uncached_awvalid,
	input  logic              uncached_awready,
	output logic [DATA_W-1:0] uncached_wdata,
	output logic [STRB_W-1:0] uncached_wstrb,
	output logic              uncached_wvalid,
	input  logic              uncached_wready,
	input  logic [1:0]        uncached_bresp,
	input  logic              uncached_bvalid,
	output logic              uncached_bready
);

	// No TLB, so kuseg and kseg2/3 map one to one
	function automatic logic [ADDR_W-1:0] to_phys(input logic [ADDR_W-1:0] vaddr);
		logic [SEG_W-1:0] seg;
		seg = vaddr[ADDR_W-1 -: SEG_W];
		if (seg == SEG_KSEG0 || seg == SEG_KSEG1)
			return {{SEG_W{1'b0}}, vaddr[ADDR_W-SEG_W-1:0]};
		return vaddr;
	endfunction

	cpu_ibus_if ibus_phys();
	cpu_dbus_if dbus_phys();

	assign ibus_phys.read    = ibus.read;
	assign ibus_phys.address = to_phys(ibus.address);
	assign ibus.rddata       = ibus_phys.rddata;
	assign ibus.stall        = ibus_phys.stall;

	assign dbus_phys.read       = dbus.read;
	assign dbus_phys.write      = dbus.write;
	assign dbus_phys.address    = to_phys(dbus.address);
	assign dbus_phys.wrdata     = dbus.wrdata;
	assign dbus_phys.byteenable = dbus.byteenable;
	assign dbus.rddata          = dbus_phys.rddata;
	assign dbus.stall           = dbus_phys.stall;

	icache icache_i (
		.aclk    (aclk),
		.rst_n   (rst_n),
		.ibus    (ibus_phys.slave),
		.araddr  (icache_araddr),
		.arlen   (icache_arlen),
		.arvalid (icache_arvalid),
		.arready (icache_arready),
		.rdata   (icache_rdata),
		.rlast   (icache_rlast),
		.rvalid  (icache_rvalid),
		.rready  (icache_rready)
	);

	uncached_bridge uncached_bridge_i (
		.aclk    (aclk),
		.rst_n   (rst_n),
		.dbus    (dbus_phys.slave),
		.araddr  (uncached_araddr),
		.arvalid (uncached_arvalid),
		.arready (uncached_arready),
		.rdata   (uncached_rdata),
		.rresp   (uncached_rresp),
		.rvalid  (uncached_rvalid),
		.rready  (uncached_rready),
		.awaddr  (uncached_awaddr),
		.awvalid (uncached_awvalid),
		.awready (uncached_awready),
		.wdata   (uncached_wdata),
		.wstrb   (uncached_wstrb),
		.wvalid  (uncached_wvalid),
		.wready  (uncached_wready),
		.bresp   (uncached_bresp),
		.bvalid  (uncached_bvalid),
		.bready  (uncached_bready)
	);

endmodule

`default_nettype wire

// File: hdl/uncached_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module uncached_bridge import bus_pkg::*; (
	input  logic              aclk,
	input  logic              rst_n,

	cpu_dbus_if.slave         dbus,

	output logic [ADDR_W-1:0] araddr,
	output logic              arvalid,
	input  logic              arready,
	input  logic [DATA_W-1:0] rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready,

	output logic [ADDR_W-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [DATA_W-1:0] wdata,
	output logic [STRB_W-1:0] wstrb,
	output logic              wvalid,
	input  logic              wready,
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready
);

	typedef enum logic [2:0] {
		br_idle,
		br_read_addr,
		br_read_data,
		br_write,
		br_write_resp,
		br_done
	} state_e;

	state_e state;

	logic [ADDR_W-1:0] addr_r;
	logic [DATA_W-1:0] wdata_r;
	logic [STRB_W-1:0] strb_r;
	logic [DATA_W-1:0] data_r;
	resp_e             resp_q;
	logic              aw_pend;
	logic              w_pend;

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state   <= br_idle;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
		end else begin
			case (state)
				br_idle: begin
					if (dbus.read) begin
						state <= br_read_addr;
					end else if (dbus.write) begin
						state   <= br_write;
						aw_pend <= 1'b1;
						w_pend  <= 1'b1;
					end
				end
				br_read_addr: begin
					if (arready)
						state <= br_read_data;
				end
				br_read_data: begin
					if (rvalid)
						state <= br_done;
				end
				br_write: begin
					// aw and w may complete in either order
					aw_pend <= aw_pend && !awready;
					w_pend  <= w_pend && !wready;
					if ((!aw_pend || awready) && (!w_pend || wready))
						state <= br_write_resp;
				end
				br_write_resp: begin
					if (bvalid)
						state <= br_done;
				end
				default: state <= br_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (state == br_idle) begin
			addr_r  <= dbus.address;
			wdata_r <= dbus.wrdata;
			strb_r  <= dbus.byteenable;
		end
		if (state == br_read_data && rvalid) begin
			data_r <= rdata;
			resp_q <= resp_e'(rresp);
		end
		if (state == br_write_resp && bvalid)
			resp_q <= resp_e'(bresp);
	end

	assign dbus.stall = (dbus.read || dbus.write) && (state != br_done);

	// Failed reads return a zero word
	assign dbus.rddata = (resp_q inside {resp_slverr, resp_decerr}) ? '0 : data_r;

	assign araddr  = addr_r;
	assign arvalid = (state == br_read_addr);
	assign rready  = (state == br_read_data);

	assign awaddr  = addr_r;
	assign awvalid = (state == br_write) && aw_pend;
	assign wdata   = wdata_r;
	assign wstrb   = strb_r;
	assign wvalid  = (state == br_write) && w_pend;
	assign bready  = (state == br_write_resp);

endmodule

`default_nettype wire

// File: hdl/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache import bus_pkg::*, mem_pkg::*; (
	input  logic              aclk,
	input  logic              rst_n,

	cpu_ibus_if.slave         ibus,

	output logic [ADDR_W-1:0] araddr,
	output logic [LEN_W-1:0]  arlen,
	output logic              arvalid,
	input  logic              arready,
	input  logic [DATA_W-1:0] rdata,
	input  logic              rlast,
	input  logic              rvalid,
	output logic              rready
);

	typedef enum logic [1:0] {
		st_lookup,
		st_request,
		st_fill,
		st_done
	} state_e;

	state_e state;

	phys_addr_u req_addr;
	phys_addr_u fill_addr;

	logic [TAG_W-1:0]  tag_mem [LINE_COUNT];
	logic [DATA_W-1:0] data_mem [LINE_COUNT*LINE_WORDS];
	logic [LINE_COUNT-1:0] valid_r;

	logic [TAG_W-1:0]    tag_q;
	logic [DATA_W-1:0]   data_q;
	logic                valid_q;
	logic [OFFSET_W-1:0] fill_off;
	logic                hit;

	assign req_addr = ibus.address;

	// Arrays answer one cycle after the address is presented
	assign hit = valid_q && (tag_q == req_addr.cache.tag);

	always_ff @(posedge aclk) begin
		if (!rst_n) begin
			state    <= st_lookup;
			valid_r  <= '0;
			valid_q  <= 1'b0;
			fill_off <= '0;
		end else begin
			valid_q <= valid_r[req_addr.cache.index];
			case (state)
				st_lookup: begin
					if (ibus.read)
						state <= st_done;
				end
				st_done: begin
					if (!ibus.read || hit) begin
						state <= st_lookup;
					end else begin
						state    <= st_request;
						fill_off <= '0;
					end
				end
				st_request: begin
					if (arready)
						state <= st_fill;
				end
				st_fill: begin
					if (rvalid) begin
						fill_off <= fill_off + 1'b1;
						if (rlast) begin
							valid_r[fill_addr.cache.index] <= 1'b1;
							// Rerun the lookup, which now hits
							state <= st_lookup;
						end
					end
				end
				default: state <= st_lookup;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		tag_q  <= tag_mem[req_addr.cache.index];
		data_q <= data_mem[{req_addr.cache.index, req_addr.cache.offset}];
		if (state == st_done && ibus.read && !hit) begin
			fill_addr.bus.line_base <= req_addr.bus.line_base;
			fill_addr.bus.low       <= '0;
		end
		if (state == st_fill && rvalid) begin
			data_mem[{fill_addr.cache.index, fill_off}] <= rdata;
			if (rlast)
				tag_mem[fill_addr.cache.index] <= fill_addr.cache.tag;
		end
	end

	assign ibus.stall  = ibus.read && !(state == st_done && hit);
	assign ibus.rddata = data_q;

	// Line-aligned incrementing burst
	assign araddr  = fill_addr;
	assign arlen   = BURST_LEN;
	assign arvalid = (state == st_request);
	assign rready  = (state == st_fill);

endmodule

`default_nettype wire

// File: hdl/cpu_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cpu_ibus_if import bus_pkg::*; ();
	logic              read;
	logic [ADDR_W-1:0] address;
	logic [DATA_W-1:0] rddata;
	logic              stall;

	modport master (
		output read, address,
		input  rddata, stall
	);

	modport slave (
		input  read, address,
		output rddata, stall
	);
endinterface

interface cpu_dbus_if import bus_pkg::*; ();
	logic              read;
	logic              write;
	logic [ADDR_W-1:0] address;
	logic [DATA_W-1:0] wrdata;
	logic [STRB_W-1:0] byteenable;
	logic [DATA_W-1:0] rddata;
	logic              stall;

	modport master (
		output read, write, address, wrdata, byteenable,
		input  rddata, stall
	);

	modport slave (
		input  read, write, address, wrdata, byteenable,
		output rddata, stall
	);
endinterface

`default_nettype wire

// File: hdl/mem_pkg.sv
`default_nettype none

package mem_pkg;
	import bus_pkg::*;

	// Instruction cache geometry
	localparam int LINE_WORDS = 4;
	localparam int LINE_COUNT = 16;
	localparam int OFFSET_W   = $clog2(LINE_WORDS);
	localparam int INDEX_W    = $clog2(LINE_COUNT);
	localparam int LINE_LSB_W = OFFSET_W + 2;
	localparam int TAG_W      = ADDR_W - INDEX_W - LINE_LSB_W;

	localparam logic [LEN_W-1:0] BURST_LEN = LEN_W'(LINE_WORDS - 1);

	// MIPS segment select, top three address bits
	localparam int SEG_W = 3;
	localparam logic [SEG_W-1:0] SEG_KSEG0 = 3'b100;
	localparam logic [SEG_W-1:0] SEG_KSEG1 = 3'b101;

	// One physical address, seen by the cache and by the bus
	typedef union packed {
		struct packed {
			logic [TAG_W-1:0]    tag;
			logic [INDEX_W-1:0]  index;
			logic [OFFSET_W-1:0] offset;
			logic [1:0]          byte_off;
		} cache;
		struct packed {
			logic [ADDR_W-LINE_LSB_W-1:0] line_base;
			logic [LINE_LSB_W-1:0]        low;
		} bus;
	} phys_addr_u;

endpackage

`default_nettype wire

// File: hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

	// CPU bus and AXI data path
	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// AXI3 burst length field
	localparam int LEN_W = 4;

	// AXI response codes
	typedef enum logic [1:0] {
		resp_okay   = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} resp_e;

endpackage

`default_nettype wire
